//--- fetch_pkg.sv
/*
 * Shared address map, line geometry and payload structs of the fetch path.
 * Both regions must be line aligned and must not overlap.
 * The program buffer holds a whole number of lines.
 */

package fetch_pkg;

    // Geometry
    localparam int PhysAddrWidth = 40;
    localparam int LineBits      = 128;
    localparam int WordBits      = 32;
    localparam int WordsPerLine  = LineBits / WordBits;  // 4
    localparam int LineBytes     = LineBits / 8;         // 16
    localparam int LineOffBits   = $clog2(LineBytes);    // Byte offset inside a line
    localparam int BeatWidth     = 2;

    // Region sizes
    localparam int BromLines      = 64;
    localparam int ProgbufWords   = 16;
    localparam int ProgbufLines   = ProgbufWords / WordsPerLine;
    localparam int LineIdxWidth   = $clog2(BromLines);   // Widest region-local index
    localparam int PbWordIdxWidth = $clog2(ProgbufWords);
    localparam int PbLineIdxWidth = $clog2(ProgbufLines);

    localparam string BromFile = "bootrom.hex";

    typedef logic [PhysAddrWidth-1:0] phys_addr_t;
    typedef logic [LineBits-1:0]      fetch_line_t;

    // Address map, inclusive bounds
    localparam phys_addr_t BromBase    = 40'h000;
    localparam phys_addr_t BromEnd     = BromBase + BromLines * LineBytes - 1;      // 0x3FF
    localparam phys_addr_t ProgbufBase = 40'h800;
    localparam phys_addr_t ProgbufEnd  = ProgbufBase + ProgbufLines * LineBytes - 1; // 0x83F

    // Core fetch request
    typedef struct packed {
        logic       valid;
        phys_addr_t paddr;
    } fetch_req_t;

    // Fetch response, refills and merged output alike
    typedef struct packed {
        logic                 valid;
        fetch_line_t          data;
        logic [BeatWidth-1:0] beat;
    } fetch_resp_t;

    // Region-local line read from the router
    typedef struct packed {
        logic                    valid;
        logic [LineIdxWidth-1:0] idx;
    } line_rd_t;

    typedef struct packed {
        logic        valid;
        fetch_line_t data;
    } line_rsp_t;

    // Word write into the program buffer
    typedef struct packed {
        logic                      en;
        logic [PbWordIdxWidth-1:0] idx;
        logic [WordBits-1:0]       data;
    } pb_write_t;

endpackage

//--- fetch_router.sv
/*
 * Uncacheable fetch decode and response merge. Purely combinational.
 * Unmapped addresses get ready low and never a response.
 * The environment must keep refills away from cycles with a memory response.
 */

`timescale 1ns/10ps

module fetch_router import fetch_pkg::*; (
    input  logic        clk_i,
    input  logic        sargantana_rstn,

    // Core side
    input  fetch_req_t  fetch_req_i,
    output logic        fetch_ready_o,

    // Memory read requests
    output line_rd_t    brom_rd_o,
    output line_rd_t    pb_rd_o,

    // Memory responses
    input  line_rsp_t   brom_rsp_i,
    input  line_rsp_t   pb_rsp_i,

    // Cache refill and merged response
    input  fetch_resp_t refill_resp_i,
    output fetch_resp_t fetch_resp_o
);

    logic       brom_hit;
    logic       pb_hit;
    phys_addr_t brom_off;
    phys_addr_t pb_off;

    function automatic logic range_check(phys_addr_t addr, phys_addr_t base, phys_addr_t last);
        return (addr >= base) && (addr <= last);
    endfunction

    // Region decode
    assign brom_hit = range_check(fetch_req_i.paddr, BromBase, BromEnd);
    assign pb_hit   = range_check(fetch_req_i.paddr, ProgbufBase, ProgbufEnd);

    // Level, independent of valid
    assign fetch_ready_o = brom_hit | pb_hit;

    // Offsets from each region base
    assign brom_off = fetch_req_i.paddr - BromBase;
    assign pb_off   = fetch_req_i.paddr - ProgbufBase;

    always_comb begin
        brom_rd_o.valid = fetch_req_i.valid & brom_hit;
        brom_rd_o.idx   = brom_off[LineOffBits +: LineIdxWidth]; // Drop byte offset
    end

    always_comb begin
        pb_rd_o.valid = fetch_req_i.valid & pb_hit;
        pb_rd_o.idx   = pb_off[LineOffBits +: LineIdxWidth];
    end

    // Response merge
    always_comb begin
        fetch_resp_o = refill_resp_i; // Refill passes through with its own beat
        if (brom_rsp_i.valid) begin
            fetch_resp_o.valid = 1'b1;
            fetch_resp_o.data  = brom_rsp_i.data;
            fetch_resp_o.beat  = '0;
        end else if (pb_rsp_i.valid) begin
            fetch_resp_o.valid = 1'b1;
            fetch_resp_o.data  = pb_rsp_i.data;
            fetch_resp_o.beat  = '0;
        end
    end

    // Regions are disjoint, so both memories can never answer at once
    a_single_mem_rsp: assert property (
        @(posedge clk_i) disable iff (!sargantana_rstn)
        !(brom_rsp_i.valid && pb_rsp_i.valid)
    ) else $error("Boot ROM and program buffer responded in the same cycle");

    // A refill here would be dropped by the merge
    a_no_refill_clash: assert property (
        @(posedge clk_i) disable iff (!sargantana_rstn)
        (brom_rsp_i.valid || pb_rsp_i.valid) |-> !refill_resp_i.valid
    ) else $error("Refill arrived together with an uncacheable response");

endmodule

//--- bootrom.sv
/*
 * Line-wide boot ROM, contents loaded from the ROM data file at elaboration.
 * One read per cycle, data registered one cycle after the request.
 */

`timescale 1ns/10ps

module bootrom import fetch_pkg::*; (
    input  logic      clk_i,
    input  logic      sargantana_rstn,
    input  line_rd_t  rd_i,
    output line_rsp_t rsp_o
);

    fetch_line_t rom [BromLines];

    logic        rsp_valid_q;
    fetch_line_t rsp_data_q;

    initial begin
        $readmemh(BromFile, rom);
    end

    // Response valid
    always_ff @(posedge clk_i, negedge sargantana_rstn) begin
        if (!sargantana_rstn) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= rd_i.valid;
        end
    end

    // Line data only moves on a read
    always_ff @(posedge clk_i) begin
        if (rd_i.valid) begin
            rsp_data_q <= rom[rd_i.idx];
        end
    end

    always_comb begin
        rsp_o.valid = rsp_valid_q;
        rsp_o.data  = rsp_data_q;
    end

endmodule

//--- progbuf.sv
/*
 * Debug program buffer. Word writes, line reads, registered read data.
 * A read in the same cycle as a write returns the old contents.
 * Contents clear to zero on reset.
 */

`timescale 1ns/10ps

module progbuf import fetch_pkg::*; (
    input  logic      clk_i,
    input  logic      sargantana_rstn,
    input  line_rd_t  rd_i,
    input  pb_write_t wr_i,
    output line_rsp_t rsp_o
);

    logic [WordBits-1:0] mem_q [ProgbufWords];

    logic [PbLineIdxWidth-1:0] rd_line;
    fetch_line_t               line_d;
    logic                      rsp_valid_q;
    fetch_line_t               rsp_data_q;

    // Word storage
    always_ff @(posedge clk_i, negedge sargantana_rstn) begin
        if (!sargantana_rstn) begin
            for (int i = 0; i < ProgbufWords; i++) begin
                mem_q[i] <= '0;
            end
        end else if (wr_i.en) begin
            mem_q[wr_i.idx] <= wr_i.data;
        end
    end

    assign rd_line = rd_i.idx[PbLineIdxWidth-1:0]; // Upper bits are zero for mapped reads

    // Gather the line, word 0 in the low bits
    always_comb begin
        for (int w = 0; w < WordsPerLine; w++) begin
            line_d[w*WordBits +: WordBits] = mem_q[rd_line * WordsPerLine + w];
        end
    end

    always_ff @(posedge clk_i, negedge sargantana_rstn) begin
        if (!sargantana_rstn) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= rd_i.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd_i.valid) begin
            rsp_data_q <= line_d; // Sampled before this edge's write lands
        end
    end

    always_comb begin
        rsp_o.valid = rsp_valid_q;
        rsp_o.data  = rsp_data_q;
    end

    // Router decode must keep reads inside the buffer
    a_rd_in_range: assert property (
        @(posedge clk_i) disable iff (!sargantana_rstn)
        rd_i.valid |-> (rd_i.idx < ProgbufLines)
    ) else $error("Program buffer read index %0d out of range", rd_i.idx);

endmodule

//--- fetch_subsystem.sv
/*
 * Uncacheable fetch subsystem: router, boot ROM and program buffer.
 * Mapped requests answer one cycle later, refills pass straight through.
 * No back-pressure on any response.
 */

`timescale 1ns/10ps

module fetch_subsystem import fetch_pkg::*; (
    input  logic        clk_i,
    input  logic        sargantana_rstn,

    // Core fetch port
    input  fetch_req_t  fetch_req_i,
    output logic        fetch_ready_o,
    output fetch_resp_t fetch_resp_o,

    // Cache refill side
    input  fetch_resp_t refill_resp_i,

    // Debug side program buffer writes
    input  pb_write_t   pb_write_i
);

    line_rd_t  brom_rd;
    line_rd_t  pb_rd;
    line_rsp_t brom_rsp;
    line_rsp_t pb_rsp;

    fetch_router fetch_router_i (
        .clk_i          (clk_i),
        .sargantana_rstn(sargantana_rstn),
        .fetch_req_i    (fetch_req_i),
        .fetch_ready_o  (fetch_ready_o),
        .brom_rd_o      (brom_rd),
        .pb_rd_o        (pb_rd),
        .brom_rsp_i     (brom_rsp),
        .pb_rsp_i       (pb_rsp),
        .refill_resp_i  (refill_resp_i),
        .fetch_resp_o   (fetch_resp_o)
    );

    bootrom bootrom_i (
        .clk_i          (clk_i),
        .sargantana_rstn(sargantana_rstn),
        .rd_i           (brom_rd),
        .rsp_o          (brom_rsp)
    );

    progbuf progbuf_i (
        .clk_i          (clk_i),
        .sargantana_rstn(sargantana_rstn),
        .rd_i           (pb_rd),
        .wr_i           (pb_write_i),
        .rsp_o          (pb_rsp)
    );

endmodule

//--- tb_fetch_subsystem.sv
/*
 * Random testbench for the fetch subsystem with a fixed seed.
 * Expected responses come from the address map, the ROM data file and a
 * shadow program buffer. Run from the project root so the ROM file is found.
 */

`timescale 1ns/10ps

module tb_fetch_subsystem import fetch_pkg::*; ();

    localparam int ClkPeriod   = 20;
    localparam int ResetCycles = 3;
    localparam int NumRomReads = 300;
    localparam int NumPbWrites = 200;
    localparam int NumUnmapped = 100;
    localparam int NumRefills  = 150;
    localparam int NumMixed    = 400;
    localparam int DrainCycles = 2;
    localparam int TotalCycles = ResetCycles + 1 + ProgbufLines + NumRomReads + NumPbWrites
                               + NumUnmapped + NumRefills + NumMixed + 6 * DrainCycles;

    logic        clk_i;
    logic        sargantana_rstn;
    fetch_req_t  fetch_req_i;
    logic        fetch_ready_o;
    fetch_resp_t refill_resp_i;
    fetch_resp_t fetch_resp_o;
    pb_write_t   pb_write_i;

    fetch_line_t         rom_model [BromLines];
    logic [WordBits-1:0] pb_shadow [ProgbufWords];
    fetch_resp_t         exp_q [$];  // Response due in the next cycle

    fetch_subsystem fetch_subsystem_i (
        .clk_i          (clk_i),
        .sargantana_rstn(sargantana_rstn),
        .fetch_req_i    (fetch_req_i),
        .fetch_ready_o  (fetch_ready_o),
        .fetch_resp_o   (fetch_resp_o),
        .refill_resp_i  (refill_resp_i),
        .pb_write_i     (pb_write_i)
    );

    always #(ClkPeriod / 2) clk_i = ~clk_i;

    function automatic logic in_rom(phys_addr_t addr);
        return (addr >= BromBase) && (addr < BromBase + BromLines * LineBytes);
    endfunction

    function automatic logic in_pb(phys_addr_t addr);
        return (addr >= ProgbufBase) && (addr < ProgbufBase + ProgbufWords * (WordBits / 8));
    endfunction

    // Model of the response one cycle after a request
    function automatic fetch_resp_t predict_resp(fetch_req_t req);
        fetch_resp_t rsp;
        phys_addr_t  line;
        rsp = '0;
        if (req.valid && in_rom(req.paddr)) begin
            line      = (req.paddr - BromBase) / LineBytes;
            rsp.valid = 1'b1;
            rsp.data  = rom_model[line];
        end else if (req.valid && in_pb(req.paddr)) begin
            line      = (req.paddr - ProgbufBase) / LineBytes;
            rsp.valid = 1'b1;
            for (int w = 0; w < WordsPerLine; w++) begin
                rsp.data[w*WordBits +: WordBits] = pb_shadow[line * WordsPerLine + w];
            end
        end
        return rsp;
    endfunction

    function automatic logic rsp_due();
        return (exp_q.size() != 0) && exp_q[0].valid;
    endfunction

    function automatic fetch_req_t make_req(logic valid, phys_addr_t addr);
        fetch_req_t req;
        req.valid = valid;
        req.paddr = addr;
        return req;
    endfunction

    function automatic phys_addr_t pick_rom_addr();
        return BromBase + phys_addr_t'($urandom_range(BromLines * LineBytes - 1, 0));
    endfunction

    function automatic phys_addr_t pick_pb_addr();
        return ProgbufBase + phys_addr_t'($urandom_range(ProgbufWords * (WordBits / 8) - 1, 0));
    endfunction

    // Mostly the gap and edges next to the regions, sometimes far away
    function automatic phys_addr_t pick_unmapped_addr();
        phys_addr_t a;
        do begin
            case ($urandom_range(3, 0))
                0: a = BromBase + BromLines * LineBytes;
                1: a = ProgbufBase - 1;
                2: a = {8'($urandom), $urandom};
                default: a = phys_addr_t'($urandom_range(32'hfff, 0));
            endcase
        end while (in_rom(a) || in_pb(a));
        return a;
    endfunction

    function automatic fetch_resp_t random_refill();
        fetch_resp_t r;
        r.valid = 1'($urandom_range(1, 0));
        r.data  = {$urandom, $urandom, $urandom, $urandom};
        r.beat  = BeatWidth'($urandom_range(3, 0));
        return r;
    endfunction

    function automatic pb_write_t random_write();
        pb_write_t w;
        w.en   = 1'b1;
        w.idx  = PbWordIdxWidth'($urandom_range(ProgbufWords - 1, 0));
        w.data = $urandom;
        return w;
    endfunction

    task automatic check_resp(input fetch_resp_t exp, input fetch_resp_t act);
        logic bad;
        bad = (act.valid !== exp.valid);
        if (exp.valid) begin
            bad = bad || (act.data !== exp.data) || (act.beat !== exp.beat);
        end
        if (bad) begin
            $display("MISMATCH fetch_resp_o at %0t: expected %h, got %h", $time, exp, act);
            $display("STATUS: FAIL");
            $fatal(1, "fetch_resp_o mismatch");
        end
    endtask

    task automatic check_ready(input logic exp, input logic act);
        if (act !== exp) begin
            $display("MISMATCH fetch_ready_o at %0t: expected %h, got %h", $time, exp, act);
            $display("STATUS: FAIL");
            $fatal(1, "fetch_ready_o mismatch");
        end
    endtask

    // One clock: drive on the rising edge, check on the falling edge
    task automatic run_cycle(input fetch_req_t req, input fetch_resp_t refill,
                             input pb_write_t wr);
        fetch_resp_t exp_rsp;
        @(posedge clk_i);
        fetch_req_i   <= req;
        refill_resp_i <= refill;
        pb_write_i    <= wr;
        if (exp_q.size() != 0) begin
            exp_rsp = exp_q.pop_front();
        end else begin
            exp_rsp = '0;
        end
        if (!exp_rsp.valid) begin
            exp_rsp = refill;  // Nothing due, refill shows through
        end
        exp_q.push_back(predict_resp(req));
        if (wr.en) begin
            pb_shadow[wr.idx] = wr.data;  // Seen by reads from the next cycle on
        end
        @(negedge clk_i);
        check_ready(in_rom(req.paddr) || in_pb(req.paddr), fetch_ready_o);
        check_resp(exp_rsp, fetch_resp_o);
    endtask

    task automatic drain_pipe();
        repeat (DrainCycles) run_cycle('0, '0, '0);
    endtask

    initial begin
        #(TotalCycles * ClkPeriod * 2);
        $display("Timeout: run did not finish within %0d clock cycles", TotalCycles * 2);
        $display("STATUS: FAIL");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        fetch_req_t  req;
        fetch_resp_t refill;
        pb_write_t   wr;
        void'($urandom(32'h1a78));
        clk_i            = 1'b0;
        sargantana_rstn <= 1'b0;
        fetch_req_i     <= '0;
        refill_resp_i   <= '0;
        pb_write_i      <= '0;
        for (int i = 0; i < ProgbufWords; i++) begin
            pb_shadow[i] = '0;
        end
        $readmemh(BromFile, rom_model);
        if ($isunknown(rom_model[0]) || $isunknown(rom_model[BromLines-1])) begin
            $display("Boot ROM data file is missing or too short for the model");
            $display("STATUS: FAIL");
            $fatal(1, "Cannot load ROM model");
        end

        // Reset state
        repeat (ResetCycles) begin
            @(posedge clk_i);
            @(negedge clk_i);
            check_resp('0, fetch_resp_o);
        end
        @(posedge clk_i);
        sargantana_rstn <= 1'b1;

        for (int l = 0; l < ProgbufLines; l++) begin
            run_cycle(make_req(1'b1, ProgbufBase + l * LineBytes), '0, '0);  // Cleared lines
        end
        drain_pipe();

        // Boot ROM reads
        repeat (NumRomReads) run_cycle(make_req(1'b1, pick_rom_addr()), '0, '0);
        drain_pipe();

        // Program buffer writes mixed with line reads
        for (int n = 0; n < NumPbWrites; n++) begin
            wr  = random_write();
            req = make_req(1'($urandom_range(1, 0)), pick_pb_addr());
            run_cycle(req, '0, wr);
        end
        drain_pipe();

        repeat (NumUnmapped) run_cycle(make_req(1'b1, pick_unmapped_addr()), '0, '0);
        drain_pipe();

        // Refills with nothing else in flight
        repeat (NumRefills) begin
            refill = random_refill();
            run_cycle('0, refill, '0);
        end
        drain_pipe();

        // Mixed back-to-back stream
        repeat (NumMixed) begin
            case ($urandom_range(2, 0))
                0: req = make_req(1'b1, pick_rom_addr());
                1: req = make_req(1'b1, pick_pb_addr());
                default: req = make_req(1'b1, pick_unmapped_addr());
            endcase
            if (rsp_due()) begin
                refill = '0;
            end else begin
                refill = random_refill();
            end
            if ($urandom_range(3, 0) == 0) begin
                wr = random_write();
            end else begin
                wr = '0;
            end
            run_cycle(req, refill, wr);
        end
        drain_pipe();

        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- bootrom.hex
// Row n holds boot ROM line n as 32 hex digits, word 0 in the low digits
// Each word is {line, ~line, word index}
00ff000300ff000200ff000100ff0000
01fe000301fe000201fe000101fe0000
02fd000302fd000202fd000102fd0000
03fc000303fc000203fc000103fc0000
04fb000304fb000204fb000104fb0000
05fa000305fa000205fa000105fa0000
06f9000306f9000206f9000106f90000
07f8000307f8000207f8000107f80000
08f7000308f7000208f7000108f70000
09f6000309f6000209f6000109f60000
0af500030af500020af500010af50000
0bf400030bf400020bf400010bf40000
0cf300030cf300020cf300010cf30000
0df200030df200020df200010df20000
0ef100030ef100020ef100010ef10000
0ff000030ff000020ff000010ff00000
10ef000310ef000210ef000110ef0000
11ee000311ee000211ee000111ee0000
12ed000312ed000212ed000112ed0000
13ec000313ec000213ec000113ec0000
14eb000314eb000214eb000114eb0000
15ea000315ea000215ea000115ea0000
16e9000316e9000216e9000116e90000
17e8000317e8000217e8000117e80000
18e7000318e7000218e7000118e70000
19e6000319e6000219e6000119e60000
1ae500031ae500021ae500011ae50000
1be400031be400021be400011be40000
1ce300031ce300021ce300011ce30000
1de200031de200021de200011de20000
1ee100031ee100021ee100011ee10000
1fe000031fe000021fe000011fe00000
20df000320df000220df000120df0000
21de000321de000221de000121de0000
22dd000322dd000222dd000122dd0000
23dc000323dc000223dc000123dc0000
24db000324db000224db000124db0000
25da000325da000225da000125da0000
26d9000326d9000226d9000126d90000
27d8000327d8000227d8000127d80000
28d7000328d7000228d7000128d70000
29d6000329d6000229d6000129d60000
2ad500032ad500022ad500012ad50000
2bd400032bd400022bd400012bd40000
2cd300032cd300022cd300012cd30000
2dd200032dd200022dd200012dd20000
2ed100032ed100022ed100012ed10000
2fd000032fd000022fd000012fd00000
30cf000330cf000230cf000130cf0000
31ce000331ce000231ce000131ce0000
32cd000332cd000232cd000132cd0000
33cc000333cc000233cc000133cc0000
34cb000334cb000234cb000134cb0000
35ca000335ca000235ca000135ca0000
36c9000336c9000236c9000136c90000
37c8000337c8000237c8000137c80000
38c7000338c7000238c7000138c70000
39c6000339c6000239c6000139c60000
3ac500033ac500023ac500013ac50000
3bc400033bc400023bc400013bc40000
3cc300033cc300023cc300013cc30000
3dc200033dc200023dc200013dc20000
3ec100033ec100023ec100013ec10000
3fc000033fc000023fc000013fc00000

//--- flist.f
fetch_pkg.sv
fetch_router.sv
bootrom.sv
progbuf.sv
fetch_subsystem.sv
tb_fetch_subsystem.sv
